// ==== logic/conv_5x5_ctrl.sv ====
`timescale 1ns/100ps

module conv_5x5_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         go,
    input  conv_geom_pkg::width_t        feature_in_width,
    output logic                         busy,
    output conv_geom_pkg::weight_addr_t  weight_addr,
    output conv_geom_pkg::bias_addr_t    bias_addr,
    output logic                         bias_valid,
    output conv_geom_pkg::feature_addr_t feature_addr_b0,
    output conv_geom_pkg::feature_addr_t feature_addr_b1,
    output logic                         feature_addr_valid,
    output logic                         conv_compute_en,
    output conv_step_pkg::field_move_t   field_move,
    output logic                         newline,
    output logic                         direction,
    output conv_step_pkg::row_in_band_t  internal_row,
    output logic                         b0_low,
    output logic                         done
);

    // shared by the address generator and the flag pipeline
    scan_step_if step_bus ();

    conv_scan_sequencer u_sequencer (
        .clk              (clk),
        .rst_n            (rst_n),
        .go               (go),
        .feature_in_width (feature_in_width),
        .busy             (busy),
        .weight_addr      (weight_addr),
        .bias_addr        (bias_addr),
        .bias_valid       (bias_valid),
        .step             (step_bus.seq)
    );

    conv_window_addr u_window_addr (
        .clk                (clk),
        .rst_n              (rst_n),
        .step               (step_bus.addr),
        .feature_in_width   (feature_in_width),
        .feature_addr_b0    (feature_addr_b0),
        .feature_addr_b1    (feature_addr_b1),
        .feature_addr_valid (feature_addr_valid)
    );

    conv_flag_align u_flag_align (
        .clk             (clk),
        .rst_n           (rst_n),
        .step            (step_bus.align),
        .conv_compute_en (conv_compute_en),
        .field_move      (field_move),
        .newline         (newline),
        .direction       (direction),
        .internal_row    (internal_row),
        .b0_low          (b0_low),
        .done            (done)
    );

endmodule

// ==== logic/conv_flag_align.sv ====
`timescale 1ns/100ps

module conv_flag_align (
    input  logic                        clk,
    input  logic                        rst_n,
    scan_step_if.align                  step,
    output logic                        conv_compute_en,
    output conv_step_pkg::field_move_t  field_move,
    output logic                        newline,
    output logic                        direction,
    output conv_step_pkg::row_in_band_t internal_row,
    output logic                        b0_low,
    output logic                        done
);

    logic [conv_step_pkg::ALIGN_STAGES-1:0] valid_sr;
    logic [conv_step_pkg::ALIGN_STAGES-1:0] last_sr;
    logic [conv_step_pkg::ALIGN_STAGES-1:0] dir_sr;
    logic [conv_step_pkg::ALIGN_STAGES-1:0] b0_low_sr;
    conv_step_pkg::field_move_t             move_sr [conv_step_pkg::ALIGN_STAGES];
    conv_step_pkg::row_in_band_t            row_sr  [conv_step_pkg::ALIGN_STAGES];

    // address register plus memory latency, several positions in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr  <= '0;
            last_sr   <= '0;
            dir_sr    <= '0;
            b0_low_sr <= '0;
            for (int i = 0; i < conv_step_pkg::ALIGN_STAGES; i++) begin
                move_sr[i] <= conv_step_pkg::MOVE_RIGHT;
                row_sr[i]  <= '0;
            end
        end else begin
            valid_sr  <= {valid_sr[conv_step_pkg::ALIGN_STAGES-2:0], step.valid};
            last_sr   <= {last_sr[conv_step_pkg::ALIGN_STAGES-2:0], step.last};
            dir_sr    <= {dir_sr[conv_step_pkg::ALIGN_STAGES-2:0], step.dir_left};
            b0_low_sr <= {b0_low_sr[conv_step_pkg::ALIGN_STAGES-2:0], step.band[0]};
            move_sr[0] <= step.move;
            row_sr[0]  <= step.row_in_band;
            for (int i = 1; i < conv_step_pkg::ALIGN_STAGES; i++) begin
                move_sr[i] <= move_sr[i-1];
                row_sr[i]  <= row_sr[i-1];
            end
        end
    end

    // flags come from the final stage, in step with the returned data
    assign conv_compute_en = valid_sr[conv_step_pkg::ALIGN_STAGES-1];
    assign field_move      = move_sr[conv_step_pkg::ALIGN_STAGES-1];
    assign newline         = conv_compute_en && (field_move == conv_step_pkg::MOVE_DOWN);
    assign direction       = dir_sr[conv_step_pkg::ALIGN_STAGES-1];
    assign internal_row    = row_sr[conv_step_pkg::ALIGN_STAGES-1];
    // odd band on top leaves block 0 below
    assign b0_low          = b0_low_sr[conv_step_pkg::ALIGN_STAGES-1];
    assign done            = conv_compute_en && last_sr[conv_step_pkg::ALIGN_STAGES-1];

endmodule

// ==== logic/conv_geom_pkg.sv ====
package conv_geom_pkg;

    // window side and cycles from feature address to data
    localparam int KERNEL_SIZE = 5;
    localparam int MEM_LATENCY = 2;

    // map width or coordinate, up to 31 columns
    localparam int WIDTH_W = 5;

    // memory address widths
    localparam int FEATURE_ADDR_W = 10;
    localparam int WEIGHT_ADDR_W  = 8;
    localparam int BIAS_ADDR_W    = 5;

    // index of a 5-row band
    localparam int BAND_W = 3;

    typedef logic [WIDTH_W-1:0]        width_t;
    typedef logic [FEATURE_ADDR_W-1:0] feature_addr_t;
    typedef logic [WEIGHT_ADDR_W-1:0]  weight_addr_t;
    typedef logic [BIAS_ADDR_W-1:0]    bias_addr_t;

endpackage

// ==== logic/conv_scan_sequencer.sv ====
`timescale 1ns/100ps

module conv_scan_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        go,
    input  conv_geom_pkg::width_t       feature_in_width,
    output logic                        busy,
    output conv_geom_pkg::weight_addr_t weight_addr,
    output conv_geom_pkg::bias_addr_t   bias_addr,
    output logic                        bias_valid,
    scan_step_if.seq                    step
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SCAN,
        ST_DRAIN
    } state_t;

    state_t                           state;
    logic [2:0]                       phase_cnt;
    conv_geom_pkg::width_t            out_w;
    conv_geom_pkg::width_t            col;
    conv_geom_pkg::width_t            row;
    logic                             dir_left;
    conv_step_pkg::row_in_band_t      row_in_band;
    logic [conv_geom_pkg::BAND_W-1:0] band;
    conv_step_pkg::field_move_t       move;
    logic                             start;
    logic                             load_last;
    logic                             row_end;
    logic                             last_pos;

    assign out_w = feature_in_width - conv_geom_pkg::width_t'(conv_step_pkg::LEAD_OFFSET);

    // go only counts while idle
    assign start     = go && (state == ST_IDLE);
    assign load_last = (state == ST_LOAD) && (phase_cnt == 3'(conv_geom_pkg::KERNEL_SIZE - 1));

    // row end depends on which way the row runs
    assign row_end  = dir_left ? (col == '0) : (col == out_w - 1'b1);
    assign last_pos = row_end && (row == out_w - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            phase_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_LOAD;
                        phase_cnt <= '0;
                    end
                end
                ST_LOAD: begin
                    if (load_last) begin
                        state     <= ST_SCAN;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                ST_SCAN: begin
                    if (last_pos) begin
                        state <= ST_DRAIN;
                    end
                end
                // wait until the last position reaches the flag outputs
                default: begin
                    if (phase_cnt == 3'(conv_geom_pkg::MEM_LATENCY - 1)) begin
                        state     <= ST_IDLE;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign busy = (state != ST_IDLE);

    // one weight row per load cycle, one bias per job; both keep counting across jobs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_addr <= '0;
            bias_addr   <= '0;
            bias_valid  <= 1'b0;
        end else begin
            bias_valid <= start;
            if (start) begin
                bias_addr <= bias_addr + 1'b1;
            end
            if (start || ((state == ST_LOAD) && !load_last)) begin
                weight_addr <= weight_addr + 1'b1;
            end
        end
    end

    // serpentine walk, band tracked as the window top moves down
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col         <= '0;
            row         <= '0;
            dir_left    <= 1'b0;
            row_in_band <= '0;
            band        <= '0;
            move        <= conv_step_pkg::MOVE_RIGHT;
        end else if (start) begin
            col         <= '0;
            row         <= '0;
            dir_left    <= 1'b0;
            row_in_band <= '0;
            band        <= '0;
            move        <= conv_step_pkg::MOVE_RIGHT;
        end else if ((state == ST_SCAN) && !last_pos) begin
            if (row_end) begin
                row      <= row + 1'b1;
                dir_left <= !dir_left;
                move     <= conv_step_pkg::MOVE_DOWN;
                if (row_in_band == conv_step_pkg::ROW_IN_BAND_LAST) begin
                    row_in_band <= '0;
                    band        <= band + 1'b1;
                end else begin
                    row_in_band <= row_in_band + 1'b1;
                end
            end else begin
                col  <= dir_left ? col - 1'b1 : col + 1'b1;
                move <= dir_left ? conv_step_pkg::MOVE_LEFT : conv_step_pkg::MOVE_RIGHT;
            end
        end
    end

    assign step.valid       = (state == ST_SCAN);
    assign step.move        = move;
    assign step.col         = col;
    assign step.row_in_band = row_in_band;
    assign step.band        = band;
    assign step.dir_left    = dir_left;
    assign step.last        = last_pos;

endmodule

// ==== logic/conv_step_pkg.sv ====
package conv_step_pkg;

    // how the window reached its current position
    typedef enum logic [1:0] {
        MOVE_RIGHT = 2'd0,
        MOVE_DOWN  = 2'd1,
        MOVE_LEFT  = 2'd2
    } field_move_t;

    // row of the window top inside its band, 0 to 4
    typedef logic [2:0] row_in_band_t;

    localparam row_in_band_t ROW_IN_BAND_LAST = row_in_band_t'(conv_geom_pkg::KERNEL_SIZE - 1);

    // leading column offset when scanning right, also the output width shrink
    localparam int LEAD_OFFSET  = conv_geom_pkg::KERNEL_SIZE - 1;
    localparam int ALIGN_STAGES = conv_geom_pkg::MEM_LATENCY + 1;

endpackage

// ==== logic/conv_window_addr.sv ====
`timescale 1ns/100ps

module conv_window_addr (
    input  logic                         clk,
    input  logic                         rst_n,
    scan_step_if.addr                    step,
    input  conv_geom_pkg::width_t        feature_in_width,
    output conv_geom_pkg::feature_addr_t feature_addr_b0,
    output conv_geom_pkg::feature_addr_t feature_addr_b1,
    output logic                         feature_addr_valid
);

    conv_geom_pkg::width_t          lead_col;
    logic [conv_geom_pkg::BAND_W:0] lower_band;
    conv_geom_pkg::feature_addr_t   upper_addr;
    conv_geom_pkg::feature_addr_t   lower_addr;

    // new column entering the window, right edge when scanning right
    assign lead_col = step.dir_left ? step.col
                                    : step.col + conv_geom_pkg::width_t'(conv_step_pkg::LEAD_OFFSET);

    assign lower_band = {1'b0, step.band} + 1'b1;

    // each block word is one band column, two bands per block row of the map
    assign upper_addr = conv_geom_pkg::feature_addr_t'(step.band >> 1)
                      * conv_geom_pkg::feature_addr_t'(feature_in_width)
                      + conv_geom_pkg::feature_addr_t'(lead_col);

    assign lower_addr = conv_geom_pkg::feature_addr_t'(lower_band >> 1)
                      * conv_geom_pkg::feature_addr_t'(feature_in_width)
                      + conv_geom_pkg::feature_addr_t'(lead_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feature_addr_valid <= 1'b0;
            feature_addr_b0    <= '0;
            feature_addr_b1    <= '0;
        end else begin
            feature_addr_valid <= step.valid;
            if (step.valid) begin
                // odd upper band sits in block 1
                if (step.band[0]) begin
                    feature_addr_b0 <= lower_addr;
                    feature_addr_b1 <= upper_addr;
                end else begin
                    feature_addr_b0 <= upper_addr;
                    feature_addr_b1 <= lower_addr;
                end
            end
        end
    end

endmodule

// ==== logic/scan_step_if.sv ====
`timescale 1ns/100ps

// one window position per cycle from the sequencer
interface scan_step_if;

    logic                             valid;
    conv_step_pkg::field_move_t       move;
    // left column of the window
    conv_geom_pkg::width_t            col;
    conv_step_pkg::row_in_band_t      row_in_band;
    // band holding the window top row
    logic [conv_geom_pkg::BAND_W-1:0] band;
    logic                             dir_left;
    logic                             last;

    modport seq (output valid, move, col, row_in_band, band, dir_left, last);

    modport addr (input valid, col, band, dir_left);

    modport align (input valid, move, row_in_band, band, dir_left, last);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_conv_5x5_ctrl --Mdir obj_dir \
    -f verilog.f

sim_out=$(./obj_dir/Vtb_conv_5x5_ctrl 2>&1) || { echo "$sim_out"; exit 1; }
echo "$sim_out"

if echo "$sim_out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== testbench/conv_5x5_ctrl_chk.sv ====
`timescale 1ns/100ps

module conv_5x5_ctrl_chk (
    input logic clk,
    input logic rst_n,
    input logic bias_valid,
    input logic feature_addr_valid,
    input logic conv_compute_en,
    input logic done
);

    // one bias fetch strobe per job
    a_bias_single: assert property (@(posedge clk) disable iff (!rst_n)
        bias_valid |=> !bias_valid)
        else $error("bias_valid high for more than one cycle");

    // data returns after the fixed memory latency
    a_compute_after_addr: assert property (@(posedge clk) disable iff (!rst_n)
        feature_addr_valid |-> ##2 conv_compute_en)
        else $error("conv_compute_en missing two cycles after feature_addr_valid");

    a_done_on_compute: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> conv_compute_en)
        else $error("done without conv_compute_en");

endmodule

bind conv_5x5_ctrl conv_5x5_ctrl_chk u_chk (
    .clk                (clk),
    .rst_n              (rst_n),
    .bias_valid         (bias_valid),
    .feature_addr_valid (feature_addr_valid),
    .conv_compute_en    (conv_compute_en),
    .done               (done)
);

// ==== testbench/tb_conv_5x5_ctrl.sv ====
`timescale 1ns/100ps

module tb_conv_5x5_ctrl;

    localparam int JOBS = 5;
    localparam int SEED = 96398;
    localparam int FA_W = conv_geom_pkg::FEATURE_ADDR_W;

    logic                         clk;
    logic                         rst_n;
    logic                         go;
    conv_geom_pkg::width_t        feature_in_width;
    logic                         busy;
    conv_geom_pkg::weight_addr_t  weight_addr;
    conv_geom_pkg::bias_addr_t    bias_addr;
    logic                         bias_valid;
    conv_geom_pkg::feature_addr_t feature_addr_b0;
    conv_geom_pkg::feature_addr_t feature_addr_b1;
    logic                         feature_addr_valid;
    logic                         conv_compute_en;
    conv_step_pkg::field_move_t   field_move;
    logic                         newline;
    logic                         direction;
    conv_step_pkg::row_in_band_t  internal_row;
    logic                         b0_low;
    logic                         done;

    // input width and expected output width per job
    int in_w_tab  [JOBS] = '{9, 10, 12, 16, 31};
    int out_w_tab [JOBS] = '{5, 6, 8, 12, 27};

    // captured per job, b0 address in the upper half
    logic [2*FA_W-1:0] addr_q [$];
    int                addr_cyc_q [$];
    // move, newline, direction, internal row, b0_low
    logic [7:0]        flag_q [$];
    int                flag_cyc_q [$];
    int                done_cyc_q [$];
    int                bias_pulses = 0;
    int                cycle_cnt = 0;

    int errors = 0;
    int checks = 0;
    int job_errors = 0;
    bit timed_out = 1'b0;
    int exp_weight = 0;
    int exp_bias = 0;

    conv_5x5_ctrl u_conv_5x5_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .go                 (go),
        .feature_in_width   (feature_in_width),
        .busy               (busy),
        .weight_addr        (weight_addr),
        .bias_addr          (bias_addr),
        .bias_valid         (bias_valid),
        .feature_addr_b0    (feature_addr_b0),
        .feature_addr_b1    (feature_addr_b1),
        .feature_addr_valid (feature_addr_valid),
        .conv_compute_en    (conv_compute_en),
        .field_move         (field_move),
        .newline            (newline),
        .direction          (direction),
        .internal_row       (internal_row),
        .b0_low             (b0_low),
        .done               (done)
    );

    always #50 clk = ~clk;

    // outputs sampled on the falling edge, away from register updates
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (feature_addr_valid) begin
            addr_q.push_back({feature_addr_b0, feature_addr_b1});
            addr_cyc_q.push_back(cycle_cnt);
        end
        if (conv_compute_en) begin
            flag_q.push_back({field_move, newline, direction, internal_row, b0_low});
            flag_cyc_q.push_back(cycle_cnt);
        end
        if (done) begin
            done_cyc_q.push_back(cycle_cnt);
        end
        if (bias_valid) begin
            bias_pulses = bias_pulses + 1;
        end
    end

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("mismatch at %0t: %s", $time, msg);
            errors++;
            job_errors++;
        end
    endtask

    task automatic wait_for_busy(input logic level, input int limit);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = (busy === level);
        end
        if (!seen) begin
            $display("timeout: busy did not reach %b within %0d cycles", level, limit);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_for_done(input int limit);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = (done === 1'b1);
        end
        if (!seen) begin
            $display("timeout: done did not pulse within %0d cycles", limit);
            timed_out = 1'b1;
            errors++;
        end else begin
            check(!busy, "busy still high on the done cycle");
        end
    endtask

    // serpentine walk rebuilt from the scan and addressing rules
    task automatic compare_job(input int w, input int ow);
        int                         idx;
        int                         col;
        int                         band;
        int                         lead;
        int                         up_addr;
        int                         lo_addr;
        bit                         left;
        conv_step_pkg::field_move_t exp_move;
        logic [2*FA_W-1:0]          exp_addr;
        logic [7:0]                 exp_flag;
        check(addr_q.size() == ow * ow,
              $sformatf("%0d address cycles, expected %0d", addr_q.size(), ow * ow));
        check(flag_q.size() == ow * ow,
              $sformatf("%0d compute cycles, expected %0d", flag_q.size(), ow * ow));
        idx = 0;
        for (int r = 0; r < ow; r++) begin
            for (int i = 0; i < ow; i++) begin
                left    = r[0];
                col     = left ? ow - 1 - i : i;
                band    = r / 5;
                lead    = left ? col : col + 4;
                up_addr = (band / 2) * w + lead;
                lo_addr = ((band + 1) / 2) * w + lead;
                if (i == 0 && r > 0) begin
                    exp_move = conv_step_pkg::MOVE_DOWN;
                end else begin
                    exp_move = left ? conv_step_pkg::MOVE_LEFT : conv_step_pkg::MOVE_RIGHT;
                end
                if (band % 2 == 1) begin
                    exp_addr = {FA_W'(lo_addr), FA_W'(up_addr)};
                end else begin
                    exp_addr = {FA_W'(up_addr), FA_W'(lo_addr)};
                end
                exp_flag = {exp_move, exp_move == conv_step_pkg::MOVE_DOWN, left,
                            3'(r % 5), 1'(band % 2)};
                if (idx < addr_q.size()) begin
                    check(addr_q[idx] == exp_addr,
                          $sformatf("position %0d addr %h, expected %h",
                                    idx, addr_q[idx], exp_addr));
                end
                if (idx < flag_q.size() && idx < addr_cyc_q.size()) begin
                    check(flag_q[idx] == exp_flag,
                          $sformatf("position %0d flags %b, expected %b",
                                    idx, flag_q[idx], exp_flag));
                    check(flag_cyc_q[idx] == addr_cyc_q[idx] + 2,
                          $sformatf("position %0d compute %0d cycles after address",
                                    idx, flag_cyc_q[idx] - addr_cyc_q[idx]));
                end
                idx++;
            end
        end
        check(done_cyc_q.size() == 1, $sformatf("%0d done pulses", done_cyc_q.size()));
        if (done_cyc_q.size() == 1 && flag_cyc_q.size() > 0) begin
            check(done_cyc_q[0] == flag_cyc_q[$], "done not on the last compute cycle");
        end
        check(bias_pulses == 1, $sformatf("%0d bias_valid pulses", bias_pulses));
        exp_weight = (exp_weight + conv_geom_pkg::KERNEL_SIZE) % 256;
        exp_bias   = (exp_bias + 1) % 32;
        check(weight_addr == conv_geom_pkg::weight_addr_t'(exp_weight),
              $sformatf("weight_addr %0d, expected %0d", weight_addr, exp_weight));
        check(bias_addr == conv_geom_pkg::bias_addr_t'(exp_bias),
              $sformatf("bias_addr %0d, expected %0d", bias_addr, exp_bias));
    endtask

    initial begin
        int gap;
        int extra;
        clk              = 1'b0;
        rst_n            = 1'b0;
        go               = 1'b0;
        feature_in_width = conv_geom_pkg::width_t'(in_w_tab[0]);
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(!busy && !bias_valid && !feature_addr_valid && !conv_compute_en
              && !newline && !done, "control outputs not low after reset");
        check(weight_addr == '0 && bias_addr == '0 && feature_addr_b0 == '0
              && feature_addr_b1 == '0, "addresses not zero after reset");
        for (int j = 0; j < JOBS && !timed_out; j++) begin
            job_errors = 0;
            gap   = 1 + ($urandom % 4);
            extra = 1 + ($urandom % 20);
            repeat (gap) @(posedge clk);
            addr_q.delete();
            addr_cyc_q.delete();
            flag_q.delete();
            flag_cyc_q.delete();
            done_cyc_q.delete();
            bias_pulses = 0;
            go               <= 1'b1;
            feature_in_width <= conv_geom_pkg::width_t'(in_w_tab[j]);
            @(posedge clk);
            go <= 1'b0;
            wait_for_busy(1'b1, 8);
            if (!timed_out) begin
                // second go in the middle of the job, must be dropped
                repeat (extra) @(posedge clk);
                go <= 1'b1;
                @(posedge clk);
                go <= 1'b0;
                wait_for_done(out_w_tab[j] * out_w_tab[j] + 40);
            end
            if (!timed_out) begin
                repeat (4) @(negedge clk);
                check(!busy, "busy rose again after done");
                compare_job(in_w_tab[j], out_w_tab[j]);
            end
            $display("job %0d: width %0d, out %0d, %0d positions, %0d errors",
                     j, in_w_tab[j], out_w_tab[j], addr_q.size(), job_errors);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/conv_geom_pkg.sv
logic/conv_step_pkg.sv
logic/scan_step_if.sv
logic/conv_scan_sequencer.sv
logic/conv_window_addr.sv
logic/conv_flag_align.sv
logic/conv_5x5_ctrl.sv
testbench/conv_5x5_ctrl_chk.sv
testbench/tb_conv_5x5_ctrl.sv
